// ==== filelist.f ====
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/pipe_link.sv
src/regfile.sv
src/fetch_stage.sv
src/decode_stage.sv
src/exec_mem_stage.sv
src/writeback_stage.sv
src/mini_cpu_top.sv
tests/tb_sram.sv
tests/tb_mini_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mini_cpu testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_mini_cpu -Mdir obj_dir -o sim_mini_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_mini_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== tests/tb_mini_cpu.sv ====
`timescale 1ns/1ps

module tb_mini_cpu;

    localparam logic [31:0] prog_base = 32'h1c00_0000;
    localparam int max_exp = 64;

    logic        clk;
    logic        rst_n;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        retire;

    logic        built;
    logic        print_pending;
    int          print_grp;
    int          cycle_cnt;
    int          prog_len;
    int          n_exp;
    int          exp_idx;
    int          skip_left;
    int          cur_grp;
    int          fail_cnt;
    logic [31:0] last_pc;
    logic [31:0] loop_pc;
    logic [31:0] regs_model [32];
    logic [31:0] mem_model [64];
    // expected trace in program order
    logic [31:0] exp_pc [max_exp];
    logic        exp_we [max_exp];
    logic [4:0]  exp_wnum [max_exp];
    logic [31:0] exp_wdata [max_exp];
    int          exp_grp [max_exp];
    int          grp_err [4];
    int          grp_cnt [4];
    string       grp_name [4];

    mini_cpu_top UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_sram u_sram (
        .clk        (clk),
        .inst_en    (inst_sram_en),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_en    (data_sram_en),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    // writeback holds a valid instruction
    assign retire = UUT.u_writeback.w_valid;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic note_fail(input int grp);
        fail_cnt++;
        if (grp >= 0)
            grp_err[grp]++;
    endtask

    task automatic put_word(input logic [31:0] w, output logic run);
        u_sram.rom[prog_len] = w;
        last_pc = prog_base + (32'(prog_len) << 2);
        prog_len++;
        run = (skip_left == 0);
        if (!run)
            skip_left--;
    endtask

    task automatic push_exp(input logic we, input logic [4:0] rd, input logic [31:0] data);
        exp_pc[n_exp]    = last_pc;
        exp_we[n_exp]    = we && (rd != 5'd0);
        exp_wnum[n_exp]  = rd;
        exp_wdata[n_exp] = data;
        exp_grp[n_exp]   = cur_grp;
        if (we && rd != 5'd0)
            regs_model[rd] = data;
        n_exp++;
    endtask

    task automatic emit_rrr(input logic is_sub, input logic [4:0] rd, input logic [4:0] rj,
                            input logic [4:0] rk);
        logic run;
        logic [31:0] res;
        put_word({is_sub ? 17'h00022 : 17'h00020, rk, rj, rd}, run);
        res = is_sub ? regs_model[rj] - regs_model[rk] : regs_model[rj] + regs_model[rk];
        if (run)
            push_exp(1'b1, rd, res);
    endtask

    task automatic emit_addi(input logic [4:0] rd, input logic [4:0] rj, input logic [11:0] imm);
        logic run;
        put_word({10'h00a, imm, rj, rd}, run);
        if (run)
            push_exp(1'b1, rd, regs_model[rj] + sext12(imm));
    endtask

    task automatic emit_lu12i(input logic [4:0] rd, input logic [19:0] imm);
        logic run;
        put_word({7'h0a, imm, rd}, run);
        if (run)
            push_exp(1'b1, rd, {imm, 12'h000});
    endtask

    task automatic emit_mem(input logic is_st, input logic [4:0] rd, input logic [4:0] rj,
                            input logic [11:0] imm);
        logic run;
        logic [31:0] addr;
        put_word({is_st ? 10'h0a6 : 10'h0a2, imm, rj, rd}, run);
        addr = regs_model[rj] + sext12(imm);
        if (run && is_st) begin
            mem_model[addr[7:2]] = regs_model[rd];
            push_exp(1'b0, rd, 32'h0);
        end else if (run) begin
            push_exp(1'b1, rd, mem_model[addr[7:2]]);
        end
    endtask

    // forward branch over skip_n words
    task automatic emit_br(input logic is_bne, input logic [4:0] rj, input logic [4:0] rd,
                           input int skip_n);
        logic run;
        logic taken;
        put_word({is_bne ? 6'h17 : 6'h16, 16'(skip_n + 1), rj, rd}, run);
        taken = is_bne ? (regs_model[rj] != regs_model[rd]) : (regs_model[rj] == regs_model[rd]);
        if (run) begin
            push_exp(1'b0, 5'd0, 32'h0);
            if (taken)
                skip_left = skip_n;
        end
    endtask

    task automatic load_program();
        logic run;
        cur_grp = 0;
        emit_lu12i(5'd1, 20'h12345);
        emit_addi(5'd2, 5'd0, 12'h7ff);
        emit_addi(5'd3, 5'd0, 12'hfff);
        emit_rrr(1'b0, 5'd4, 5'd3, 5'd3);
        emit_rrr(1'b1, 5'd5, 5'd0, 5'd3);
        emit_lu12i(5'd6, 20'h80000);
        emit_rrr(1'b0, 5'd7, 5'd6, 5'd6);
        emit_rrr(1'b0, 5'd0, 5'd1, 5'd2);
        emit_rrr(1'b0, 5'd8, 5'd0, 5'd2);
        // dependencies at distance 1, 2 and 3
        cur_grp = 1;
        emit_addi(5'd10, 5'd0, 12'h005);
        emit_addi(5'd11, 5'd10, 12'h003);
        emit_rrr(1'b1, 5'd12, 5'd11, 5'd10);
        emit_rrr(1'b0, 5'd13, 5'd10, 5'd11);
        emit_rrr(1'b0, 5'd14, 5'd12, 5'd13);
        cur_grp = 2;
        emit_addi(5'd20, 5'd0, 12'h040);
        emit_lu12i(5'd21, 20'hdead0);
        emit_addi(5'd21, 5'd21, 12'h5be);
        emit_mem(1'b1, 5'd21, 5'd20, 12'h000);
        emit_mem(1'b0, 5'd22, 5'd20, 12'h000);
        emit_rrr(1'b0, 5'd23, 5'd22, 5'd22);
        emit_mem(1'b0, 5'd24, 5'd20, 12'h008);
        emit_addi(5'd25, 5'd24, 12'h001);
        cur_grp = 3;
        emit_addi(5'd26, 5'd0, 12'h007);
        emit_br(1'b0, 5'd26, 5'd26, 2);
        emit_addi(5'd27, 5'd0, 12'h001);
        emit_addi(5'd27, 5'd0, 12'h002);
        emit_br(1'b1, 5'd26, 5'd26, 1);
        emit_addi(5'd28, 5'd0, 12'h003);
        emit_br(1'b1, 5'd26, 5'd0, 1);
        emit_addi(5'd28, 5'd0, 12'h009);
        emit_br(1'b0, 5'd26, 5'd0, 1);
        emit_addi(5'd29, 5'd26, 12'h001);
        // parks the core on a self loop
        put_word({6'h16, 16'h0000, 5'd0, 5'd0}, run);
        loop_pc = last_pc;
    endtask

    a_reset_quiet: assert property (
        @(posedge clk) (cycle_cnt >= 1 && (!rst_n || $rose(rst_n))) |->
            (debug_wb_rf_we == 4'h0 && !data_sram_en)
    ) else begin
        $display("[FAIL] debug_wb_rf_we/data_sram_en in reset: %h/%h",
                 $sampled(debug_wb_rf_we), $sampled(data_sram_en));
        note_fail(-1);
    end

    a_first_fetch: assert property (
        @(posedge clk) $rose(rst_n) |-> (inst_sram_en && inst_sram_addr == prog_base)
    ) else begin
        $display("[FAIL] inst_sram_addr: got %h, expected %h", $sampled(inst_sram_addr), prog_base);
        note_fail(-1);
    end

    // instruction port is read-only
    a_inst_ro: assert property (
        @(posedge clk) cycle_cnt >= 1 |-> (inst_sram_we == 4'h0 && inst_sram_wdata == 32'h0)
    ) else begin
        $display("[FAIL] inst_sram_we/inst_sram_wdata: got %h/%h, expected 0/00000000",
                 $sampled(inst_sram_we), $sampled(inst_sram_wdata));
        note_fail(-1);
    end

    a_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        (retire && exp_idx < n_exp) |-> debug_wb_pc == exp_pc[exp_idx]
    ) else begin
        $display("[FAIL] debug_wb_pc: got %h, expected %h",
                 $sampled(debug_wb_pc), exp_pc[$sampled(exp_idx)]);
        note_fail(exp_grp[$sampled(exp_idx)]);
    end

    a_we: assert property (
        @(posedge clk) disable iff (!rst_n)
        (retire && exp_idx < n_exp) |-> debug_wb_rf_we == {4{exp_we[exp_idx]}}
    ) else begin
        $display("[FAIL] debug_wb_rf_we: got %h at pc %h, expected %h", $sampled(debug_wb_rf_we),
                 exp_pc[$sampled(exp_idx)], {4{exp_we[$sampled(exp_idx)]}});
        note_fail(exp_grp[$sampled(exp_idx)]);
    end

    a_wnum: assert property (
        @(posedge clk) disable iff (!rst_n)
        (retire && exp_idx < n_exp && exp_we[exp_idx]) |-> debug_wb_rf_wnum == exp_wnum[exp_idx]
    ) else begin
        $display("[FAIL] debug_wb_rf_wnum: got %h, expected %h",
                 $sampled(debug_wb_rf_wnum), exp_wnum[$sampled(exp_idx)]);
        note_fail(exp_grp[$sampled(exp_idx)]);
    end

    a_wdata: assert property (
        @(posedge clk) disable iff (!rst_n)
        (retire && exp_idx < n_exp && exp_we[exp_idx]) |->
            debug_wb_rf_wdata == exp_wdata[exp_idx]
    ) else begin
        $display("[FAIL] debug_wb_rf_wdata: got %h at pc %h, expected %h",
                 $sampled(debug_wb_rf_wdata), exp_pc[$sampled(exp_idx)],
                 exp_wdata[$sampled(exp_idx)]);
        note_fail(exp_grp[$sampled(exp_idx)]);
    end

    a_no_stray: assert property (
        @(posedge clk) disable iff (!rst_n)
        (retire && exp_idx >= n_exp) |-> debug_wb_pc == loop_pc
    ) else begin
        $display("[FAIL] debug_wb_pc: got %h after the program end, expected %h",
                 $sampled(debug_wb_pc), loop_pc);
        note_fail(-1);
    end

    // trace bookkeeping, a group report goes out one edge after its last retirement
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        print_pending <= 1'b0;
        if (print_pending)
            $display("test %s: %0d instructions checked, %0d errors",
                     grp_name[print_grp], grp_cnt[print_grp], grp_err[print_grp]);
        if (rst_n && retire && exp_idx < n_exp) begin
            grp_cnt[exp_grp[exp_idx]]++;
            if (exp_idx == n_exp - 1 || exp_grp[exp_idx + 1] != exp_grp[exp_idx]) begin
                print_pending <= 1'b1;
                print_grp <= exp_grp[exp_idx];
            end
            exp_idx <= exp_idx + 1;
        end
    end

    initial begin
        rst_n = 1'b0;
        built = 1'b0;
        print_pending = 1'b0;
        print_grp = 0;
        cycle_cnt = 0;
        prog_len = 0;
        n_exp = 0;
        exp_idx = 0;
        skip_left = 0;
        fail_cnt = 0;
        grp_name = '{"arith", "forward", "memory", "branch"};
        grp_err = '{0, 0, 0, 0};
        grp_cnt = '{0, 0, 0, 0};
        void'($urandom(68160));
        for (int i = 0; i < 64; i++) begin
            // words outside the program decode as unimplemented
            u_sram.rom[i] = {26'h3ff_ffff, 6'(i)};
            u_sram.ram[i] = $urandom;
            mem_model[i] = u_sram.ram[i];
        end
        for (int i = 0; i < 32; i++)
            regs_model[i] = 32'h0;
        load_program();
        built = 1'b1;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        wait (exp_idx == n_exp);
        repeat (2) @(posedge clk);
        $display("summary: %0d of %0d instructions checked, %0d failures",
                 exp_idx, n_exp, fail_cnt);
        if (fail_cnt == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // four cycles per instruction plus margin
    initial begin
        wait (built);
        repeat (prog_len * 4 + 50) @(posedge clk);
        $display("timeout: only %0d of %0d instructions retired", exp_idx, n_exp);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/tb_sram.sv ====
`timescale 1ns/1ps

// instruction ROM and data RAM, one-cycle synchronous read
module tb_sram (
    input  logic        clk,
    input  logic        inst_en,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    input  logic        data_en,
    input  logic [3:0]  data_we,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata
);

    // 64 words each, indexed by word address
    logic [31:0] rom [64];
    logic [31:0] ram [64];

    always_ff @(posedge clk) begin
        if (inst_en) begin
            inst_rdata <= rom[inst_addr[7:2]];
        end
    end

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (data_en) begin
            data_rdata <= ram[data_addr[7:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_we[b]) begin
                    ram[data_addr[7:2]][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== src/mini_cpu_top.sv ====
`timescale 1ns/1ps

module mini_cpu_top (
    input  logic        clk,
    input  logic        rst_n,
    // instruction SRAM
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data SRAM
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // retirement trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pipe_pkg::*;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    pipe_link #(.payload_t(fd_payload_t)) fd_link ();
    pipe_link #(.payload_t(de_payload_t)) de_link ();
    pipe_link #(.payload_t(ew_payload_t)) ew_link ();

    fwd_t                  fwd_ex;
    fwd_t                  fwd_wb;
    logic                  redirect;
    logic [31:0]           redirect_pc;
    logic [reg_addr_w-1:0] rf_raddr1;
    logic [reg_addr_w-1:0] rf_raddr2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    // instruction memory is read-only from the core
    assign inst_sram_we    = 4'h0;
    assign inst_sram_wdata = 32'h0;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .fd              (fd_link.src)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .fd          (fd_link.dst),
        .de          (de_link.src),
        .fwd_ex      (fwd_ex),
        .fwd_wb      (fwd_wb),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    exec_mem_stage u_exec_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .de              (de_link.dst),
        .ew              (ew_link.src),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .fwd_ex          (fwd_ex)
    );

    writeback_stage u_writeback (
        .clk               (clk),
        .rst_n             (rst_n),
        .ew                (ew_link.dst),
        .data_sram_rdata   (data_sram_rdata),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .fwd_wb            (fwd_wb),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    regfile #(
        .xlen       (xlen),
        .reg_addr_w (reg_addr_w)
    ) u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

// ==== src/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
    input  logic               clk,
    input  logic               rst_n,
    pipe_link.dst              ew,
    input  logic [31:0]        data_sram_rdata,
    output logic               rf_we,
    output logic [4:0]         rf_waddr,
    output logic [31:0]        rf_wdata,
    output cpu_pipe_pkg::fwd_t fwd_wb,
    output logic [31:0]        debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output logic [4:0]         debug_wb_rf_wnum,
    output logic [31:0]        debug_wb_rf_wdata
);
    import cpu_pipe_pkg::*;

    logic        w_valid;
    ew_payload_t w_pl;

    // last stage, never back-pressures
    assign ew.allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_valid <= 1'b0;
        end else begin
            w_valid <= ew.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ew.valid) begin
            w_pl <= ew.payload;
        end
    end

    // SRAM read data lands in this cycle
    assign rf_wdata = w_pl.is_load ? data_sram_rdata : w_pl.result;
    assign rf_we    = w_valid && w_pl.rf_we;
    assign rf_waddr = w_pl.dest;

    assign fwd_wb.valid   = rf_we;
    assign fwd_wb.is_load = w_pl.is_load;
    assign fwd_wb.addr    = w_pl.dest;
    assign fwd_wb.data    = rf_wdata;

    assign debug_wb_pc       = w_pl.pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = w_pl.dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== src/exec_mem_stage.sv ====
`timescale 1ns/1ps

module exec_mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    pipe_link.dst              de,
    pipe_link.src              ew,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_we,
    output logic [31:0]        data_sram_addr,
    output logic [31:0]        data_sram_wdata,
    output cpu_pipe_pkg::fwd_t fwd_ex
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic        e_valid;
    de_payload_t e_pl;
    logic [31:0] alu_out;
    logic        to_wb;
    ew_payload_t ew_pl;

    assign de.allowin = !e_valid || ew.allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else if (de.allowin) begin
            e_valid <= de.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (de.valid && de.allowin) begin
            e_pl <= de.payload;
        end
    end

    always_comb begin
        case (e_pl.alu_op)
            alu_sub: alu_out = e_pl.src1 - e_pl.src2;
            alu_lui: alu_out = e_pl.src2;
            default: alu_out = e_pl.src1 + e_pl.src2;
        endcase
    end

    // memory access goes out on the edge that hands over to writeback
    assign to_wb = e_valid && ew.allowin;

    assign data_sram_en    = to_wb && (e_pl.is_load || e_pl.is_store);
    assign data_sram_we    = {4{to_wb && e_pl.is_store}};
    assign data_sram_addr  = alu_out;
    assign data_sram_wdata = e_pl.st_data;

    assign ew_pl.pc      = e_pl.pc;
    assign ew_pl.result  = alu_out;
    assign ew_pl.is_load = e_pl.is_load;
    assign ew_pl.rf_we   = e_pl.rf_we;
    assign ew_pl.dest    = e_pl.dest;

    assign ew.valid   = e_valid;
    assign ew.payload = ew_pl;

    // data is only meaningful when is_load is clear
    assign fwd_ex.valid   = e_valid && e_pl.rf_we;
    assign fwd_ex.is_load = e_pl.is_load;
    assign fwd_ex.addr    = e_pl.dest;
    assign fwd_ex.data    = alu_out;

    // word stores only
    a_we_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_sram_we != 4'h0) |-> (data_sram_en && data_sram_addr[1:0] == 2'b00)
    ) else $error("data SRAM write strobe without enable or to an unaligned address");

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    pipe_link.dst              fd,
    pipe_link.src              de,
    input  cpu_pipe_pkg::fwd_t fwd_ex,
    input  cpu_pipe_pkg::fwd_t fwd_wb,
    output logic [4:0]         rf_raddr1,
    output logic [4:0]         rf_raddr2,
    input  logic [31:0]        rf_rdata1,
    input  logic [31:0]        rf_rdata2,
    output logic               redirect,
    output logic [31:0]        redirect_pc
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic        d_valid;
    fd_payload_t d_pl;
    dec_op_t     op;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [31:0] si12_ext;
    logic [31:0] lui_imm;
    logic [31:0] br_offs;
    logic        use1;
    logic        use2;
    logic        stall;
    logic        fire;
    logic [31:0] val1;
    logic [31:0] val2;
    de_payload_t de_pl;

    // exec_mem wins over writeback, writeback over the register file
    function automatic logic [31:0] fwd_pick(
        input logic [4:0]  addr,
        input fwd_t        ex,
        input fwd_t        wb,
        input logic [31:0] rf_val
    );
        if (ex.valid && ex.addr == addr)
            return ex.data;
        if (wb.valid && wb.addr == addr)
            return wb.data;
        return rf_val;
    endfunction

    assign rd = d_pl.inst[4:0];
    assign rj = d_pl.inst[9:5];
    assign rk = d_pl.inst[14:10];
    assign si12_ext = {{20{d_pl.inst[21]}}, d_pl.inst[21:10]};
    assign lui_imm  = {d_pl.inst[24:5], 12'h000};
    assign br_offs  = {{14{d_pl.inst[25]}}, d_pl.inst[25:10], 2'b00};

    always_comb begin
        op = op_nop;
        if (d_pl.inst[31:15] == opc_add_w)
            op = op_add;
        else if (d_pl.inst[31:15] == opc_sub_w)
            op = op_sub;
        else if (d_pl.inst[31:22] == opc_addi_w)
            op = op_addi;
        else if (d_pl.inst[31:25] == opc_lu12i_w)
            op = op_lu12i;
        else if (d_pl.inst[31:22] == opc_ld_w)
            op = op_ld;
        else if (d_pl.inst[31:22] == opc_st_w)
            op = op_st;
        else if (d_pl.inst[31:26] == opc_beq)
            op = op_beq;
        else if (d_pl.inst[31:26] == opc_bne)
            op = op_bne;
    end

    assign use1 = op inside {op_add, op_sub, op_addi, op_ld, op_st, op_beq, op_bne};
    assign use2 = op inside {op_add, op_sub, op_st, op_beq, op_bne};

    // st.w and branches read rd as second source
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (op == op_add || op == op_sub) ? rk : rd;

    assign val1 = fwd_pick(rf_raddr1, fwd_ex, fwd_wb, rf_rdata1);
    assign val2 = fwd_pick(rf_raddr2, fwd_ex, fwd_wb, rf_rdata2);

    // load data only exists once the load reaches writeback
    assign stall = d_valid && fwd_ex.valid && fwd_ex.is_load &&
                   ((use1 && fwd_ex.addr == rf_raddr1) ||
                    (use2 && fwd_ex.addr == rf_raddr2));

    assign fire = d_valid && !stall && de.allowin;
    assign fd.allowin = !d_valid || (de.allowin && !stall);
    assign de.valid = d_valid && !stall;

    assign redirect = fire && ((op == op_beq && val1 == val2) ||
                               (op == op_bne && val1 != val2));
    assign redirect_pc = d_pl.pc + br_offs;

    always_comb begin
        de_pl.pc       = d_pl.pc;
        de_pl.alu_op   = alu_add;
        de_pl.src1     = val1;
        de_pl.src2     = si12_ext;
        de_pl.st_data  = val2;
        de_pl.is_load  = (op == op_ld);
        de_pl.is_store = (op == op_st);
        de_pl.rf_we    = op inside {op_add, op_sub, op_addi, op_lu12i, op_ld};
        de_pl.dest     = rd;
        if (op == op_add || op == op_sub)
            de_pl.src2 = val2;
        if (op == op_sub)
            de_pl.alu_op = alu_sub;
        if (op == op_lu12i) begin
            de_pl.alu_op = alu_lui;
            de_pl.src2   = lui_imm;
        end
        // writes to r0 are dropped at the source
        if (rd == 5'd0)
            de_pl.rf_we = 1'b0;
    end

    assign de.payload = de_pl;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (fd.allowin) begin
            d_valid <= fd.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fd.valid && fd.allowin) begin
            d_pl <= fd.payload;
        end
    end

    // a taken branch leaves an empty decode slot behind it
    a_redirect_no_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect |-> !stall ##1 !d_valid
    ) else $error("redirect during stall or wrong-path word reached decode");

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    pipe_link.src       fd
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    // request in flight, its word is on inst_sram_rdata this cycle
    logic        f_valid;
    logic [31:0] f_pc;
    // address of the next new request
    logic [31:0] next_pc;
    logic        hold;
    fd_payload_t f_pl;

    assign hold = f_valid && !fd.allowin;

    // fixed one-cycle SRAM, a request goes out every cycle
    assign inst_sram_en = 1'b1;
    // on back-pressure re-read the same word so rdata stays put
    assign inst_sram_addr = hold ? f_pc : next_pc;

    assign f_pl.pc   = f_pc;
    assign f_pl.inst = inst_sram_rdata;
    assign fd.payload = f_pl;
    // word behind a taken branch is dropped here
    assign fd.valid = f_valid && !redirect;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid <= 1'b0;
            next_pc <= reset_pc;
        end else if (redirect) begin
            // request issued on this edge is wrong-path
            f_valid <= 1'b0;
            next_pc <= redirect_pc;
        end else if (!hold) begin
            f_valid <= 1'b1;
            next_pc <= next_pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!redirect && !hold) begin
            f_pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        inst_sram_addr[1:0] == 2'b00 && f_pc[1:0] == 2'b00
    ) else $error("fetch address not word aligned");

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile #(
    parameter int xlen       = 32,
    parameter int reg_addr_w = 5
) (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/pipe_link.sv ====
`timescale 1ns/1ps

// valid/allowin link between two pipeline stages
interface pipe_link #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     allowin;
    payload_t payload;

    // upstream stage
    modport src (
        output valid,
        output payload,
        input  allowin
    );

    // downstream stage
    modport dst (
        input  valid,
        input  payload,
        output allowin
    );

endinterface

// ==== src/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fd_payload_t;

    typedef struct packed {
        logic [31:0]           pc;
        cpu_isa_pkg::alu_op_t  alu_op;
        logic [31:0]           src1;
        logic [31:0]           src2;
        // rd value for st.w
        logic [31:0]           st_data;
        logic                  is_load;
        logic                  is_store;
        logic                  rf_we;
        logic [4:0]            dest;
    } de_payload_t;

    typedef struct packed {
        logic [31:0] pc;
        // alu result, or load address for ld.w
        logic [31:0] result;
        logic        is_load;
        logic        rf_we;
        logic [4:0]  dest;
    } ew_payload_t;

    // bypass record published by exec_mem and writeback
    typedef struct packed {
        logic        valid;
        logic        is_load;
        logic [4:0]  addr;
        logic [31:0] data;
    } fwd_t;

endpackage

// ==== src/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // first fetch address after reset
    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // 3R-type, compared against inst[31:15]
    localparam logic [16:0] opc_add_w = 17'h00020;
    localparam logic [16:0] opc_sub_w = 17'h00022;

    // 2RI12-type, compared against inst[31:22]
    localparam logic [9:0] opc_addi_w = 10'h00a;
    localparam logic [9:0] opc_ld_w   = 10'h0a2;
    localparam logic [9:0] opc_st_w   = 10'h0a6;

    // 1RI20-type, compared against inst[31:25]
    localparam logic [6:0] opc_lu12i_w = 7'h0a;

    // branches, compared against inst[31:26]
    localparam logic [5:0] opc_beq = 6'h16;
    localparam logic [5:0] opc_bne = 6'h17;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_addi,
        op_lu12i,
        op_ld,
        op_st,
        op_beq,
        op_bne,
        op_nop
    } dec_op_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_lui
    } alu_op_t;

endpackage
